/* hw/mipsPkg.sv */
`default_nettype none

package mipsPkg;

    typedef logic [31:0] wordT;    // Data or address word
    typedef logic [4:0]  regAddrT; // Register index
    typedef logic [4:0]  shamtT;   // Shift amount field
    typedef logic [3:0]  byteEnT;  // Avalon byte lanes

    // Primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_J     = 6'b000010,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_ADDIU = 6'b001001,
        OP_SLTI  = 6'b001010,
        OP_SLTIU = 6'b001011,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_XORI  = 6'b001110,
        OP_LUI   = 6'b001111,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcodeT;

    // R-format function field, instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_JR   = 6'b001000,
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funcT;

    typedef enum logic [3:0] {
        ALU_AND, ALU_OR, ALU_XOR, ALU_ADD, ALU_SUB, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_PASSB
    } aluOpT;

    typedef enum logic [2:0] {
        FETCH     = 3'd0,
        DECODE    = 3'd1,
        EXEC      = 3'd2,
        MEM       = 3'd3,
        WRITEBACK = 3'd4,
        HALTED    = 3'd5
    } cpuStateT;

    localparam wordT defaultResetVector = 32'hBFC0_0000; // MIPS boot ROM
    localparam wordT haltAddress = 32'h0000_0000;        // Fetch here ends the run
    localparam byteEnT byteEnAll = 4'b1111;              // Word access only

endpackage

`default_nettype wire

/* hw/regFile.sv */
`timescale 1ns/1ns
`default_nettype none

module regFile (
    input  logic             clk,
    input  logic             reset,
    input  logic             regWrite,
    input  mipsPkg::regAddrT wrAddr,
    input  mipsPkg::wordT    wrData,
    input  mipsPkg::regAddrT rdAddrA,
    input  mipsPkg::regAddrT rdAddrB,
    output mipsPkg::wordT    rdDataA,
    output mipsPkg::wordT    rdDataB,
    output mipsPkg::wordT    registerV0
);
    import mipsPkg::*;

    wordT regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && wrAddr != 5'd0) begin // $zero never written
            regs[wrAddr] <= wrData;
        end
    end

    // Asynchronous read ports
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];
    assign registerV0 = regs[2]; // $v0 for debug

endmodule

`default_nettype wire

/* hw/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  mipsPkg::aluOpT  aluOp,
    input  mipsPkg::wordT   a,
    input  mipsPkg::wordT   b,
    input  mipsPkg::shamtT  shamt,
    output mipsPkg::wordT   result,
    output logic            zero
);
    import mipsPkg::*;

    logic ltSigned;
    logic ltUnsigned;

    assign ltSigned = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;

    always_comb begin
        case (aluOp)
            ALU_AND:   result = a & b;
            ALU_OR:    result = a | b;
            ALU_XOR:   result = a ^ b;
            ALU_ADD:   result = a + b;          // No overflow trap
            ALU_SUB:   result = a - b;          // Also the BEQ/BNE compare
            ALU_SLT:   result = {31'd0, ltSigned};
            ALU_SLTU:  result = {31'd0, ltUnsigned};
            // Shifts act on rt, which sits on b
            ALU_SLL:   result = b << shamt;
            ALU_SRL:   result = b >> shamt;
            ALU_SRA:   result = wordT'($signed(b) >>> shamt); // Sign fill
            ALU_LUI:   result = {b[15:0], 16'h0000};
            ALU_PASSB: result = b;
            default:   result = b;
        endcase
    end

    assign zero = (result == '0); // Drives branch resolution

endmodule

`default_nettype wire

/* hw/fetchUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module fetchUnit #(
    parameter mipsPkg::wordT resetVector = mipsPkg::defaultResetVector
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          fetchStart,
    input  logic          fetchDone,
    input  mipsPkg::wordT rdata,
    input  logic          branchTaken,
    input  mipsPkg::wordT branchTarget,
    input  logic          instrDone,
    output logic          fetchReq,
    output mipsPkg::wordT fetchAddr,
    output mipsPkg::wordT instr,
    output logic          pcHalted
);
    import mipsPkg::*;

    wordT pc;
    wordT redirectTarget;   // Branch target waiting out the delay slot
    logic redirectPending;
    logic busy;             // Fetch outstanding on the bus
    logic atHalt;

    assign atHalt = (pc == haltAddress);
    assign pcHalted = fetchStart && atHalt;        // No read issued for address zero
    assign fetchReq = (fetchStart && !atHalt) || busy;
    assign fetchAddr = pc;                          // PC only moves on instrDone

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetVector;
            busy <= 1'b0;
            redirectPending <= 1'b0;
        end else begin
            if (fetchDone) begin
                busy <= 1'b0;
            end else if (fetchStart && !atHalt) begin
                busy <= 1'b1;                       // Held through waitrequest
            end
            if (instrDone) begin
                // Step two applies the target after the delay slot
                if (redirectPending) begin
                    pc <= redirectTarget;
                end else begin
                    pc <= pc + 32'd4;
                end
                redirectPending <= branchTaken;     // Step one marks it pending
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchDone) begin
            instr <= rdata;
        end
        if (instrDone && branchTaken) begin
            redirectTarget <= branchTarget;
        end
    end

endmodule

`default_nettype wire

/* hw/loadStoreUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module loadStoreUnit (
    input  logic          clk,
    input  logic          reset,
    input  logic          memStart,
    input  logic          memWrite,
    input  mipsPkg::wordT addr,
    input  mipsPkg::wordT storeData,
    input  logic          dataDone,
    input  mipsPkg::wordT rdata,
    output logic          dataReq,
    output logic          dataWrite,
    output mipsPkg::wordT dataAddr,
    output mipsPkg::wordT dataWdata,
    output mipsPkg::wordT loadData
);
    import mipsPkg::*;

    wordT addrQ;
    wordT wdataQ;
    logic writeQ;
    logic busy;

    // Start cycle drives straight from the inputs, later cycles from the copies
    assign dataReq = memStart || busy;
    assign dataWrite = busy ? writeQ : memWrite;
    assign dataAddr = busy ? addrQ : addr;
    assign dataWdata = busy ? wdataQ : storeData;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (dataDone) begin
            busy <= 1'b0;
        end else if (memStart) begin
            busy <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (memStart) begin
            addrQ <= addr;
            wdataQ <= storeData;
            writeQ <= memWrite;
        end
        if (dataDone && !dataWrite) begin
            loadData <= rdata;  // Read for WRITEBACK
        end
    end

    // Only whole-word accesses are supported
    aWordAligned: assert property (@(posedge clk) disable iff (reset)
        memStart |-> addr[1:0] == 2'b00);

endmodule

`default_nettype wire

/* hw/busArbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module busArbiter (
    input  logic            clk,
    input  logic            reset,
    input  logic            fetchReq,
    input  mipsPkg::wordT   fetchAddr,
    input  logic            dataReq,
    input  logic            dataWrite,
    input  mipsPkg::wordT   dataAddr,
    input  mipsPkg::wordT   dataWdata,
    input  logic            waitrequest,
    output logic            fetchDone,
    output logic            dataDone,
    output mipsPkg::wordT   address,
    output logic            read,
    output logic            write,
    output mipsPkg::wordT   writedata,
    output mipsPkg::byteEnT byteenable
);
    import mipsPkg::*;

    logic locked;     // Grant frozen during waitrequest
    logic ownerData;  // Locked owner, 1 for data
    logic selData;
    logic xfer;

    // Data side wins unless a fetch already holds the bus
    assign selData = locked ? ownerData : dataReq;

    assign read = selData ? (dataReq && !dataWrite) : fetchReq;
    assign write = selData && dataReq && dataWrite;
    assign address = selData ? dataAddr : fetchAddr;
    assign writedata = dataWdata;
    assign byteenable = (read || write) ? byteEnAll : '0;

    assign xfer = read || write;
    assign fetchDone = xfer && !selData && !waitrequest; // Single-cycle strobes
    assign dataDone = xfer && selData && !waitrequest;

    always_ff @(posedge clk) begin
        if (reset) begin
            locked <= 1'b0;
            ownerData <= 1'b0;
        end else if (xfer && waitrequest) begin
            locked <= 1'b1;
            ownerData <= selData;
        end else if (xfer) begin
            locked <= 1'b0;  // Completed this cycle
        end
    end

    aNoReadWrite: assert property (@(posedge clk) disable iff (reset)
        !(read && write));

    // Command held while the slave stalls
    aHoldOnWait: assert property (@(posedge clk) disable iff (reset)
        xfer && waitrequest |=> $stable({address, read, write, writedata}));

endmodule

`default_nettype wire

/* hw/controlUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module controlUnit (
    input  logic             clk,
    input  logic             reset,
    input  mipsPkg::wordT    instr,
    input  mipsPkg::wordT    pc,
    input  logic             fetchDone,
    input  logic             dataDone,
    input  mipsPkg::wordT    rdDataA,
    input  mipsPkg::wordT    rdDataB,
    input  mipsPkg::wordT    aluResult,
    input  logic             aluZero,
    input  mipsPkg::wordT    loadData,
    input  logic             pcHalted,
    output logic             fetchStart,
    output logic             memStart,
    output logic             memWrite,
    output mipsPkg::regAddrT rdAddrA,
    output mipsPkg::regAddrT rdAddrB,
    output mipsPkg::aluOpT   aluOp,
    output mipsPkg::wordT    aluA,
    output mipsPkg::wordT    aluB,
    output mipsPkg::shamtT   shamt,
    output logic             regWrite,
    output mipsPkg::regAddrT wrAddr,
    output mipsPkg::wordT    wrData,
    output logic             branchTaken,
    output mipsPkg::wordT    branchTarget,
    output logic             instrDone,
    output logic             active
);
    import mipsPkg::*;

    cpuStateT state;
    opcodeT   opcode;
    funcT     func;
    wordT     immSext;
    wordT     immZext;
    wordT     pcPlus4;
    wordT     nextTarget;
    logic     isRType;
    logic     isJr;
    logic     isLoad;
    logic     isStore;
    logic     useImm;
    logic     zeroExt;
    logic     writesReg;
    logic     takeBranch;
    logic     booted;   // First fetch after reset kicked off

    // Field split, instr is stable from DECODE to WRITEBACK
    assign opcode = opcodeT'(instr[31:26]);
    assign func = funcT'(instr[5:0]);
    assign rdAddrA = instr[25:21];  // rs
    assign rdAddrB = instr[20:16];  // rt
    assign shamt = instr[10:6];
    assign immSext = {{16{instr[15]}}, instr[15:0]};
    assign immZext = {16'h0000, instr[15:0]};

    assign isRType = (opcode == OP_RTYPE);
    assign isJr = isRType && (func == FN_JR);
    assign isLoad = (opcode == OP_LW);
    assign isStore = (opcode == OP_SW);
    assign useImm = !isRType && opcode != OP_BEQ && opcode != OP_BNE;
    assign zeroExt = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);
    assign writesReg = !(isStore || isJr || opcode == OP_BEQ || opcode == OP_BNE
                         || opcode == OP_J);

    assign memWrite = isStore;
    assign wrAddr = isRType ? instr[15:11] : instr[20:16]; // rd or rt
    assign wrData = isLoad ? loadData : aluResult;
    assign instrDone = (state == WRITEBACK);

    always_comb begin
        aluOp = ALU_ADD;  // Address calc and ADDIU
        case (opcode)
            OP_RTYPE: begin
                case (func)
                    FN_SLL:  aluOp = ALU_SLL;
                    FN_SRL:  aluOp = ALU_SRL;
                    FN_SRA:  aluOp = ALU_SRA;
                    FN_SUBU: aluOp = ALU_SUB;
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_XOR:  aluOp = ALU_XOR;
                    FN_SLT:  aluOp = ALU_SLT;
                    FN_SLTU: aluOp = ALU_SLTU;
                    default: aluOp = ALU_ADD;
                endcase
            end
            OP_BEQ, OP_BNE: aluOp = ALU_SUB;  // Zero flag means equal
            OP_SLTI:  aluOp = ALU_SLT;
            OP_SLTIU: aluOp = ALU_SLTU;
            OP_ANDI:  aluOp = ALU_AND;
            OP_ORI:   aluOp = ALU_OR;
            OP_XORI:  aluOp = ALU_XOR;
            OP_LUI:   aluOp = ALU_LUI;
            OP_J:     aluOp = ALU_PASSB;
            default:  aluOp = ALU_ADD;
        endcase
    end

    // Targets are relative to the delay slot address
    assign pcPlus4 = pc + 32'd4;
    always_comb begin
        if (opcode == OP_J) begin
            nextTarget = {pcPlus4[31:28], instr[25:0], 2'b00};
        end else if (isJr) begin
            nextTarget = aluA;
        end else begin
            nextTarget = pcPlus4 + {immSext[29:0], 2'b00};
        end
    end
    assign takeBranch = (opcode == OP_BEQ && aluZero) || (opcode == OP_BNE && !aluZero)
                        || opcode == OP_J || isJr;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
            active <= 1'b1;
            booted <= 1'b0;
            fetchStart <= 1'b0;
            memStart <= 1'b0;
            regWrite <= 1'b0;
            branchTaken <= 1'b0;
        end else begin
            fetchStart <= 1'b0;  // Strobes last one cycle
            memStart <= 1'b0;
            case (state)
                FETCH: begin
                    if (!booted) begin
                        fetchStart <= 1'b1;
                        booted <= 1'b1;
                    end
                    if (pcHalted) begin
                        state <= HALTED;
                        active <= 1'b0;
                    end else if (fetchDone) begin
                        state <= DECODE;
                    end
                end
                DECODE: state <= EXEC;
                EXEC: begin
                    branchTaken <= takeBranch;  // Level held until WRITEBACK
                    memStart <= isLoad || isStore;
                    state <= MEM;
                end
                MEM: begin
                    if (!(isLoad || isStore) || dataDone) begin
                        regWrite <= writesReg;
                        state <= WRITEBACK;
                    end
                end
                WRITEBACK: begin
                    regWrite <= 1'b0;
                    branchTaken <= 1'b0;
                    fetchStart <= 1'b1;
                    state <= FETCH;
                end
                default: state <= HALTED;  // Stays until reset
            endcase
        end
    end

    // Operand and target registers
    always_ff @(posedge clk) begin
        if (state == DECODE) begin
            aluA <= rdDataA;
            aluB <= useImm ? (zeroExt ? immZext : immSext) : rdDataB;
        end
        if (state == EXEC) begin
            branchTarget <= nextTarget;
        end
    end

    aWriteInWb: assert property (@(posedge clk) disable iff (reset)
        regWrite |-> state == WRITEBACK);

endmodule

`default_nettype wire

/* hw/mipsCpuBus.sv */
`timescale 1ns/1ns
`default_nettype none

module mipsCpuBus #(
    parameter mipsPkg::wordT resetVector = mipsPkg::defaultResetVector
) (
    input  logic            clk,
    input  logic            reset,
    output logic            active,
    output mipsPkg::wordT   registerV0,
    // Avalon master
    output mipsPkg::wordT   address,
    output logic            read,
    output logic            write,
    input  logic            waitrequest,
    output mipsPkg::wordT   writedata,
    output mipsPkg::byteEnT byteenable,
    input  mipsPkg::wordT   readdata
);
    import mipsPkg::*;

    // Fetch and data sides of the arbiter
    logic    fetchReq;
    logic    fetchDone;
    wordT    fetchAddr;
    logic    dataReq;
    logic    dataDone;
    logic    dataWrite;
    wordT    dataAddr;
    wordT    dataWdata;

    // Control and datapath
    wordT    instr;
    logic    pcHalted;
    logic    fetchStart;
    logic    memStart;
    logic    memWrite;
    regAddrT rdAddrA;
    regAddrT rdAddrB;
    wordT    rdDataA;
    wordT    rdDataB;
    aluOpT   aluOp;
    wordT    aluA;
    wordT    aluB;
    shamtT   shamt;
    wordT    aluResult;
    logic    aluZero;
    logic    regWrite;
    regAddrT wrAddr;
    wordT    wrData;
    wordT    loadData;
    logic    branchTaken;
    wordT    branchTarget;
    logic    instrDone;

    controlUnit controlUnit_i (
        .clk(clk), .reset(reset), .instr(instr), .pc(fetchAddr),
        .fetchDone(fetchDone), .dataDone(dataDone),
        .rdDataA(rdDataA), .rdDataB(rdDataB),
        .aluResult(aluResult), .aluZero(aluZero), .loadData(loadData),
        .pcHalted(pcHalted), .fetchStart(fetchStart), .memStart(memStart),
        .memWrite(memWrite), .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
        .aluOp(aluOp), .aluA(aluA), .aluB(aluB), .shamt(shamt),
        .regWrite(regWrite), .wrAddr(wrAddr), .wrData(wrData),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .instrDone(instrDone), .active(active)
    );

    regFile regFile_i (
        .clk(clk), .reset(reset), .regWrite(regWrite),
        .wrAddr(wrAddr), .wrData(wrData),
        .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
        .rdDataA(rdDataA), .rdDataB(rdDataB), .registerV0(registerV0)
    );

    alu alu_i (
        .aluOp(aluOp), .a(aluA), .b(aluB), .shamt(shamt),
        .result(aluResult), .zero(aluZero)
    );

    fetchUnit #(.resetVector(resetVector)) fetchUnit_i (
        .clk(clk), .reset(reset), .fetchStart(fetchStart),
        .fetchDone(fetchDone), .rdata(readdata),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .instrDone(instrDone), .fetchReq(fetchReq), .fetchAddr(fetchAddr),
        .instr(instr), .pcHalted(pcHalted)
    );

    // Store data comes from rt, address from the ALU
    loadStoreUnit loadStoreUnit_i (
        .clk(clk), .reset(reset), .memStart(memStart), .memWrite(memWrite),
        .addr(aluResult), .storeData(rdDataB), .dataDone(dataDone),
        .rdata(readdata), .dataReq(dataReq), .dataWrite(dataWrite),
        .dataAddr(dataAddr), .dataWdata(dataWdata), .loadData(loadData)
    );

    busArbiter busArbiter_i (
        .clk(clk), .reset(reset),
        .fetchReq(fetchReq), .fetchAddr(fetchAddr),
        .dataReq(dataReq), .dataWrite(dataWrite),
        .dataAddr(dataAddr), .dataWdata(dataWdata),
        .waitrequest(waitrequest),
        .fetchDone(fetchDone), .dataDone(dataDone),
        .address(address), .read(read), .write(write),
        .writedata(writedata), .byteenable(byteenable)
    );

endmodule

`default_nettype wire

/* verification/tbMipsCpuBus.sv */
`timescale 1ns/1ns
`default_nettype none

module tbMipsCpuBus;

    localparam logic [31:0] bootAddr = 32'hBFC0_0000;  // Handed to the DUT as resetVector
    localparam logic [31:0] haltAddr = 32'h0000_0000;
    localparam int stimWords = 512;                    // Three words per record
    localparam time driveDelay = 5;

    logic        clk;
    logic        reset;
    logic        waitrequest;
    logic [31:0] readdata;
    logic        active;
    logic [31:0] registerV0;
    logic [31:0] address;
    logic        read;
    logic        write;
    logic [31:0] writedata;
    logic [3:0]  byteenable;

    logic [31:0] stim [stimWords];
    logic [31:0] memAddr [$];     // Sparse memory as address/word pairs
    logic [31:0] memData [$];
    logic [31:0] storeAddr [$];   // Expected stores, oldest first
    logic [31:0] storeData [$];
    logic [31:0] expectedV0;
    int          expectedStores;
    int          storesSeen;
    int          budget;          // Instructions the program executes, with margin
    int          cycleLimit;
    int          cycles;
    integer      seed;
    int          waitLeft;        // Wait cycles still owed to the current transfer
    logic        inTransfer;
    logic        stalled;         // waitrequest was high last cycle
    logic [31:0] heldAddr;
    logic [31:0] heldWdata;
    logic        heldWrite;
    logic        firstRead;

    mipsCpuBus #(.resetVector(bootAddr)) mipsCpuBus_i (
        .clk(clk), .reset(reset), .active(active), .registerV0(registerV0),
        .address(address), .read(read), .write(write), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;  // 40 ns period

    task automatic failRun(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            failRun($sformatf("Fail %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    function automatic logic [31:0] readWord(input logic [31:0] addr);
        for (int i = 0; i < memAddr.size(); i++) begin
            if (memAddr[i] == addr) begin
                return memData[i];
            end
        end
        return addr ^ 32'h5A5A_A5A5;  // Unloaded words follow the address
    endfunction

    task automatic writeWord(input logic [31:0] addr, input logic [31:0] data);
        int slot;
        slot = -1;
        for (int i = 0; i < memAddr.size(); i++) begin
            if (memAddr[i] == addr) begin
                slot = i;
            end
        end
        if (slot < 0) begin
            memAddr.push_back(addr);
            memData.push_back(data);
        end else begin
            memData[slot] = data;
        end
    endtask

    // Kind 1 memory word, 2 expected store, 3 final registerV0, 4 budget, 0 ends
    task automatic loadStim();
        int pos;
        for (int i = 0; i < stimWords; i++) begin
            stim[i] = '0;
        end
        $readmemh("verification/programStim.txt", stim);
        pos = 0;
        budget = 0;
        expectedStores = 0;
        while (pos + 2 < stimWords && stim[pos] != 0) begin
            case (stim[pos])
                1: begin
                    writeWord(stim[pos + 1], stim[pos + 2]);
                end
                2: begin
                    storeAddr.push_back(stim[pos + 1]);
                    storeData.push_back(stim[pos + 2]);
                    expectedStores++;
                end
                3: expectedV0 = stim[pos + 2];
                4: budget = stim[pos + 2];
                default: failRun($sformatf("Unknown record kind %h in the stimulus file",
                                           stim[pos]));
            endcase
            pos += 3;
        end
        if (budget == 0) begin
            failRun("The stimulus file gives no instruction budget");
        end
        cycleLimit = budget * 5 * 4;  // 5 states, up to 4x for bus waits
    endtask

    task automatic recordStore();
        logic [31:0] expAddr;
        logic [31:0] expData;
        if (storeAddr.size() == 0) begin
            failRun($sformatf("Unexpected store of %h to address %h", writedata, address));
        end else begin
            expAddr = storeAddr.pop_front();
            expData = storeData.pop_front();
            checkValue("address", address, expAddr);
            checkValue("writedata", writedata, expData);
            writeWord(address, writedata);  // Later loads see it
            storesSeen++;
        end
    endtask

    // Avalon slave side, runs once per cycle after the DUT has settled
    task automatic serveBus();
        if (reset) begin
            if (read === 1'b1 || write === 1'b1) begin
                failRun("A bus transfer was started during reset");
            end
            checkValue("active", active, 32'd1);
            inTransfer = 1'b0;
            stalled = 1'b0;
            waitrequest = 1'b0;
            readdata = 'x;
        end else if (read || write) begin
            if (read && write) begin
                failRun("read and write are high in the same cycle");
            end
            checkValue("byteenable", byteenable, 32'hF);
            if (stalled) begin
                checkValue("address", address, heldAddr);  // Command frozen while stalled
                checkValue("write", write, heldWrite);
                if (write) begin
                    checkValue("writedata", writedata, heldWdata);
                end
            end
            if (!inTransfer) begin
                if (!active) begin
                    failRun("A bus transfer was started after the CPU halted");
                end
                if (read && address == haltAddr) begin
                    failRun("A read was issued to the halt address");
                end
                if (read && !firstRead) begin
                    firstRead = 1'b1;
                    checkValue("address", address, bootAddr);  // First fetch
                end
                inTransfer = 1'b1;
                waitLeft = $unsigned($random(seed)) % 4;  // 0 to 3 waits
                heldAddr = address;
                heldWrite = write;
                heldWdata = writedata;
            end
            if (waitLeft > 0) begin
                waitLeft--;
                waitrequest = 1'b1;
                stalled = 1'b1;
                readdata = 'x;
            end else begin
                waitrequest = 1'b0;  // Completes at the next edge
                stalled = 1'b0;
                inTransfer = 1'b0;
                if (write) begin
                    recordStore();
                end else begin
                    readdata = readWord(address);
                end
            end
        end else begin
            if (inTransfer) begin
                failRun("A request was dropped before its transfer completed");
            end
            waitrequest = 1'b0;
            stalled = 1'b0;
            readdata = 'x;
        end
    endtask

    always @(posedge clk) begin
        #driveDelay;
        serveBus();
    end

    always @(posedge clk) begin
        if (reset) begin
            cycles = 0;
        end else begin
            cycles = cycles + 1;
            if (cycles >= cycleLimit) begin
                failRun($sformatf("Timeout: the CPU did not halt within %0d cycles",
                                  cycleLimit));
            end
        end
    end

    initial begin
        seed = 4921;
        reset = 1'b1;
        waitrequest = 1'b0;
        readdata = '0;
        inTransfer = 1'b0;
        stalled = 1'b0;
        firstRead = 1'b0;
        storesSeen = 0;
        waitLeft = 0;
        loadStim();
        repeat (2) @(posedge clk);
        #driveDelay;
        reset = 1'b0;
        while (active === 1'b1) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);  // Bus must stay idle once halted
        checkValue("active", active, 32'd0);
        if (!firstRead) begin
            failRun("No instruction fetch was seen on the bus");
        end
        checkValue("store count", storesSeen, expectedStores);
        checkValue("registerV0", registerV0, expectedV0);
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/programStim.txt */
// Columns: kind address data, all hex
// Kind 1 memory word, 2 expected store in order, 3 final registerV0, 4 instruction budget
// Program at the reset vector, $8 data base, $9 = -5, $10 = 7
1 BFC00000 34081000
1 BFC00004 2409FFFB
1 BFC00008 340A0007
1 BFC0000C 012A5821
1 BFC00010 AD0B0000
1 BFC00014 01495823
1 BFC00018 AD0B0004
1 BFC0001C 012A5824
1 BFC00020 AD0B0008
1 BFC00024 012A5825
1 BFC00028 AD0B000C
1 BFC0002C 012A5826
1 BFC00030 AD0B0010
1 BFC00034 012A582A
1 BFC00038 AD0B0014
1 BFC0003C 012A582B
1 BFC00040 AD0B0018
1 BFC00044 000A5900
1 BFC00048 AD0B001C
1 BFC0004C 00095902
1 BFC00050 AD0B0020
1 BFC00054 00095843
1 BFC00058 AD0B0024
// Immediate ops
1 BFC0005C 312BFF0F
1 BFC00060 AD0B0028
1 BFC00064 394B8001
1 BFC00068 AD0B002C
1 BFC0006C 294BFFFC
1 BFC00070 AD0B0030
1 BFC00074 2D4BFFFF
1 BFC00078 AD0B0034
1 BFC0007C 3C0B1234
1 BFC00080 AD0B0038
// Loads of a preloaded and a stored word, then stored again
1 BFC00084 8D0C0100
1 BFC00088 8D0D0004
1 BFC0008C AD0C003C
1 BFC00090 AD0D0040
// BEQ taken, BNE taken, BEQ not taken, J, JR to zero, each with a delay slot
1 BFC00094 114A0002
1 BFC00098 AD0A0044
1 BFC0009C AD090044
1 BFC000A0 152A0002
1 BFC000A4 AD090048
1 BFC000A8 AD0A0048
1 BFC000AC 112A0003
1 BFC000B0 34020100
1 BFC000B4 24420001
1 BFC000B8 0BF00031
1 BFC000BC 24420010
1 BFC000C0 24421000
1 BFC000C4 00000008
1 BFC000C8 AD02004C
// Preloaded data word
1 00001100 CAFEF00D
// Stores the program must make
2 00001000 00000002
2 00001004 0000000C
2 00001008 00000003
2 0000100C FFFFFFFF
2 00001010 FFFFFFFC
2 00001014 00000001
2 00001018 00000000
2 0000101C 00000070
2 00001020 0FFFFFFF
2 00001024 FFFFFFFD
2 00001028 0000FF0B
2 0000102C 00008006
2 00001030 00000000
2 00001034 00000001
2 00001038 12340000
2 0000103C CAFEF00D
2 00001040 0000000C
2 00001044 00000007
2 00001048 FFFFFFFB
2 0000104C 00000111
3 00000000 00000111
4 00000000 00000032
0 00000000 00000000

/* tb.f */
hw/mipsPkg.sv
hw/regFile.sv
hw/alu.sv
hw/fetchUnit.sv
hw/loadStoreUnit.sv
hw/busArbiter.sv
hw/controlUnit.sv
hw/mipsCpuBus.sv
verification/tbMipsCpuBus.sv

/* Bender.yml */
package:
  name: mips_cpu_bus

sources:
  - files:
      - hw/mipsPkg.sv
      - hw/regFile.sv
      - hw/alu.sv
      - hw/fetchUnit.sv
      - hw/loadStoreUnit.sv
      - hw/busArbiter.sv
      - hw/controlUnit.sv
      - hw/mipsCpuBus.sv
  - target: simulation
    files:
      - verification/tbMipsCpuBus.sv
